//--- logic/id_ex_skid.sv
`timescale 1ns/1ps

module id_ex_skid #(
    parameter int DATA_W = 32
) (
    input  logic              clk_i,
    input  logic              reset_i,
    input  logic              in_valid_i,
    input  logic [DATA_W-1:0] in_data_i,
    output logic              in_ready_o,
    output logic              out_valid_o,
    output logic [DATA_W-1:0] out_data_o,
    input  logic              out_ready_i
);

    logic [1:0]        count_q;
    logic [DATA_W-1:0] head_q;
    logic [DATA_W-1:0] tail_q;
    logic              push;
    logic              pop;

    // Both handshake outputs come straight from the count register
    assign in_ready_o  = (count_q != 2'd2);
    assign out_valid_o = (count_q != 2'd0);
    assign out_data_o  = head_q;

    assign push = in_valid_i && in_ready_o;
    assign pop  = out_valid_o && out_ready_i;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            count_q <= 2'd0;
        end else begin
            case ({push, pop})
                2'b10:   count_q <= count_q + 2'd1;
                2'b01:   count_q <= count_q - 2'd1;
                default: count_q <= count_q;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        // New word goes to the head when the head is free or leaves now
        if (push && ((count_q == 2'd0) || ((count_q == 2'd1) && pop))) begin
            head_q <= in_data_i;
        end else if (pop && (count_q == 2'd2)) begin
            head_q <= tail_q;
        end
        // Second entry only fills while the head stays put
        if (push && (count_q == 2'd1) && !pop) begin
            tail_q <= in_data_i;
        end
    end

endmodule

//--- logic/rv_ctrl_decoder.sv
`timescale 1ns/1ps
`include "rv_decode_settings.svh"

module rv_ctrl_decoder (
    input  rv_decode_pkg::instr_u   instr_i,
    output logic                    illegal_o,
    output logic                    rf_we_o,
    output logic                    op_a_pc_o,
    output logic                    op_b_imm_o,
    output logic                    lsu_re_o,
    output logic                    lsu_we_o,
    output logic                    lsu_unsigned_o,
    output logic                    is_branch_o,
    output logic                    is_jump_o,
    output logic [`ALU_OP_W-1:0]    alu_op_o,
    output logic [`WB_SEL_W-1:0]    wb_sel_o,
    output logic [`MEM_W_W-1:0]     lsu_width_o,
    output logic [`BR_OP_W-1:0]     br_op_o,
    output logic [`IMM_SEL_W-1:0]   imm_sel_o,
    output logic [`REG_ADDR_W-1:0]  rd_o,
    output logic [`REG_ADDR_W-1:0]  rs1_o,
    output logic [`REG_ADDR_W-1:0]  rs2_o
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic       illegal;

    // Shared by OP and OP-IMM, alt picks SUB or SRA
    function automatic logic [`ALU_OP_W-1:0] alu_from_funct(input logic [2:0] f3,
                                                            input logic alt);
        logic [`ALU_OP_W-1:0] op;
        case (f3)
            `F3_ADD_SUB: op = alt ? `ALU_SUB : `ALU_ADD;
            `F3_SLL:     op = `ALU_SLL;
            `F3_SLT:     op = `ALU_SLT;
            `F3_SLTU:    op = `ALU_SLTU;
            `F3_XOR:     op = `ALU_XOR;
            `F3_SRL_SRA: op = alt ? `ALU_SRA : `ALU_SRL;
            `F3_OR:      op = `ALU_OR;
            default:     op = `ALU_AND;
        endcase
        return op;
    endfunction

    assign opcode = instr_i.r_type.opcode;
    assign funct3 = instr_i.r_type.funct3;
    assign funct7 = instr_i.r_type.funct7;

    assign rd_o  = instr_i.r_type.rd;
    assign rs1_o = instr_i.r_type.rs1;
    assign rs2_o = instr_i.r_type.rs2;

    always_comb begin
        illegal        = 1'b0;
        rf_we_o        = 1'b0;
        op_a_pc_o      = 1'b0;
        op_b_imm_o     = 1'b0;
        lsu_re_o       = 1'b0;
        lsu_we_o       = 1'b0;
        lsu_unsigned_o = 1'b0;
        is_branch_o    = 1'b0;
        is_jump_o      = 1'b0;
        alu_op_o       = `ALU_ADD;
        wb_sel_o       = `WB_ALU;
        lsu_width_o    = `MEM_BYTE;
        br_op_o        = '0;
        imm_sel_o      = `IMM_Z;

        case (opcode)
            `OPC_LUI: begin
                imm_sel_o  = `IMM_U;
                rf_we_o    = 1'b1;
                op_b_imm_o = 1'b1;
                alu_op_o   = `ALU_B;
            end
            `OPC_AUIPC: begin
                imm_sel_o  = `IMM_U;
                rf_we_o    = 1'b1;
                op_a_pc_o  = 1'b1;
                op_b_imm_o = 1'b1;
            end
            `OPC_OP_IMM: begin
                imm_sel_o  = `IMM_I;
                rf_we_o    = 1'b1;
                op_b_imm_o = 1'b1;
                // Only shift immediates carry a funct7 field
                if (funct3 == `F3_SLL) begin
                    illegal = (funct7 != `F7_BASE);
                end else if (funct3 == `F3_SRL_SRA) begin
                    illegal = (funct7 != `F7_BASE) && (funct7 != `F7_ALT);
                end
                alu_op_o = alu_from_funct(funct3, (funct3 == `F3_SRL_SRA) && funct7[5]);
            end
            `OPC_OP: begin
                rf_we_o = 1'b1;
                if (funct7 == `F7_ALT) begin
                    illegal = (funct3 != `F3_ADD_SUB) && (funct3 != `F3_SRL_SRA);
                end else begin
                    // M extension words land here with funct7 of 1
                    illegal = (funct7 != `F7_BASE);
                end
                alu_op_o = alu_from_funct(funct3, funct7[5]);
            end
            `OPC_LOAD: begin
                imm_sel_o      = `IMM_I;
                rf_we_o        = 1'b1;
                op_b_imm_o     = 1'b1;
                lsu_re_o       = 1'b1;
                wb_sel_o       = `WB_MEM;
                lsu_width_o    = funct3[1:0];
                lsu_unsigned_o = funct3[2];
                // LD, LWU and the unused code 111
                illegal = (funct3[1:0] == 2'b11) || (funct3[2] && funct3[1]);
            end
            `OPC_STORE: begin
                imm_sel_o   = `IMM_S;
                op_b_imm_o  = 1'b1;
                lsu_we_o    = 1'b1;
                lsu_width_o = funct3[1:0];
                illegal     = funct3[2] || (funct3[1:0] == 2'b11);
            end
            `OPC_BRANCH: begin
                imm_sel_o   = `IMM_B;
                is_branch_o = 1'b1;
                br_op_o     = funct3;
                illegal     = (funct3[2:1] == 2'b01);
                // EQ/NE compare by subtraction, LT/GE by set-less-than
                case (funct3[2:1])
                    2'b10:   alu_op_o = `ALU_SLT;
                    2'b11:   alu_op_o = `ALU_SLTU;
                    default: alu_op_o = `ALU_SUB;
                endcase
            end
            `OPC_JAL: begin
                imm_sel_o  = `IMM_J;
                rf_we_o    = 1'b1;
                is_jump_o  = 1'b1;
                wb_sel_o   = `WB_PC4;
                op_a_pc_o  = 1'b1;
                op_b_imm_o = 1'b1;
            end
            `OPC_JALR: begin
                imm_sel_o  = `IMM_I;
                rf_we_o    = 1'b1;
                is_jump_o  = 1'b1;
                wb_sel_o   = `WB_PC4;
                op_b_imm_o = 1'b1;
                illegal    = (funct3 != `F3_JALR);
            end
            default: begin
                illegal = 1'b1;
            end
        endcase

        // No side effects may leave the stage for an illegal word
        if (illegal) begin
            rf_we_o     = 1'b0;
            lsu_re_o    = 1'b0;
            lsu_we_o    = 1'b0;
            is_branch_o = 1'b0;
            is_jump_o   = 1'b0;
        end
        illegal_o = illegal;
    end

endmodule

//--- logic/rv_decode_pkg.sv
`include "rv_decode_settings.svh"

package rv_decode_pkg;

    typedef struct packed {
        logic [6:0]             funct7;
        logic [`REG_ADDR_W-1:0] rs2;
        logic [`REG_ADDR_W-1:0] rs1;
        logic [2:0]             funct3;
        logic [`REG_ADDR_W-1:0] rd;
        logic [6:0]             opcode;
    } r_type_t;

    typedef struct packed {
        logic [11:0]            imm;
        logic [`REG_ADDR_W-1:0] rs1;
        logic [2:0]             funct3;
        logic [`REG_ADDR_W-1:0] rd;
        logic [6:0]             opcode;
    } i_type_t;

    typedef struct packed {
        logic [6:0]             imm_11_5;
        logic [`REG_ADDR_W-1:0] rs2;
        logic [`REG_ADDR_W-1:0] rs1;
        logic [2:0]             funct3;
        logic [4:0]             imm_4_0;
        logic [6:0]             opcode;
    } s_type_t;

    // Branch offset bits are scattered around the register fields
    typedef struct packed {
        logic                   imm_12;
        logic [5:0]             imm_10_5;
        logic [`REG_ADDR_W-1:0] rs2;
        logic [`REG_ADDR_W-1:0] rs1;
        logic [2:0]             funct3;
        logic [3:0]             imm_4_1;
        logic                   imm_11;
        logic [6:0]             opcode;
    } b_type_t;

    typedef struct packed {
        logic [19:0]            imm_31_12;
        logic [`REG_ADDR_W-1:0] rd;
        logic [6:0]             opcode;
    } u_type_t;

    typedef struct packed {
        logic                   imm_20;
        logic [9:0]             imm_10_1;
        logic                   imm_11;
        logic [7:0]             imm_19_12;
        logic [`REG_ADDR_W-1:0] rd;
        logic [6:0]             opcode;
    } j_type_t;

    // One instruction word, seen through every base format
    typedef union packed {
        logic [`XLEN-1:0] raw;
        r_type_t          r_type;
        i_type_t          i_type;
        s_type_t          s_type;
        b_type_t          b_type;
        u_type_t          u_type;
        j_type_t          j_type;
    } instr_u;

endpackage

//--- logic/rv_decode_settings.svh
`ifndef RV_DECODE_SETTINGS_SVH
`define RV_DECODE_SETTINGS_SVH

// Datapath widths
`define XLEN        32
`define REG_ADDR_W  5

// RV32I major opcodes
`define OPC_LUI     7'b0110111
`define OPC_AUIPC   7'b0010111
`define OPC_JAL     7'b1101111
`define OPC_JALR    7'b1100111
`define OPC_BRANCH  7'b1100011
`define OPC_LOAD    7'b0000011
`define OPC_STORE   7'b0100011
`define OPC_OP_IMM  7'b0010011
`define OPC_OP      7'b0110011

// funct3 codes of the integer ALU group
`define F3_ADD_SUB  3'b000
`define F3_SLL      3'b001
`define F3_SLT      3'b010
`define F3_SLTU     3'b011
`define F3_XOR      3'b100
`define F3_SRL_SRA  3'b101
`define F3_OR       3'b110
`define F3_AND      3'b111
`define F3_JALR     3'b000

// funct7 codes, ALT selects SUB and SRA
`define F7_BASE     7'b0000000
`define F7_ALT      7'b0100000

// ALU operation codes
`define ALU_OP_W    4
`define ALU_ADD     4'd0
`define ALU_SUB     4'd1
`define ALU_SLL     4'd2
`define ALU_SLT     4'd3
`define ALU_SLTU    4'd4
`define ALU_XOR     4'd5
`define ALU_SRL     4'd6
`define ALU_SRA     4'd7
`define ALU_OR      4'd8
`define ALU_AND     4'd9
`define ALU_B       4'd10

// Immediate formats
`define IMM_SEL_W   3
`define IMM_I       3'd0
`define IMM_S       3'd1
`define IMM_B       3'd2
`define IMM_U       3'd3
`define IMM_J       3'd4
`define IMM_Z       3'd5

// Write-back sources
`define WB_SEL_W    2
`define WB_ALU      2'd0
`define WB_MEM      2'd1
`define WB_PC4      2'd2

// Memory access widths, equal to funct3[1:0]
`define MEM_W_W     2
`define MEM_BYTE    2'd0
`define MEM_HALF    2'd1
`define MEM_WORD    2'd2

// Branch condition is funct3 itself
`define BR_OP_W     3

// Register addresses, nine flags and the coded fields
`define CTRL_W      (3 * `REG_ADDR_W + 9 + `ALU_OP_W + `WB_SEL_W + `MEM_W_W + `BR_OP_W)

`endif

//--- logic/rv_decode_stage.sv
`timescale 1ns/1ps
`include "rv_decode_settings.svh"

module rv_decode_stage (
    input  logic                    clk_i,
    input  logic                    reset_i,
    input  logic [`XLEN-1:0]        instr_i,
    input  logic                    instr_valid_i,
    output logic                    instr_ready_o,
    output logic                    dec_valid_o,
    input  logic                    dec_ready_i,
    output logic [`REG_ADDR_W-1:0]  rd_o,
    output logic [`REG_ADDR_W-1:0]  rs1_o,
    output logic [`REG_ADDR_W-1:0]  rs2_o,
    output logic [`XLEN-1:0]        imm_o,
    output logic                    illegal_o,
    output logic                    rf_we_o,
    output logic [`WB_SEL_W-1:0]    wb_sel_o,
    output logic [`ALU_OP_W-1:0]    alu_op_o,
    output logic                    op_a_pc_o,
    output logic                    op_b_imm_o,
    output logic                    lsu_re_o,
    output logic                    lsu_we_o,
    output logic [`MEM_W_W-1:0]     lsu_width_o,
    output logic                    lsu_unsigned_o,
    output logic                    is_branch_o,
    output logic                    is_jump_o,
    output logic [`BR_OP_W-1:0]     br_op_o
);

    import rv_decode_pkg::*;

    localparam int PAYLOAD_W = `CTRL_W + `XLEN;

    instr_u                  instr_w;
    logic [`IMM_SEL_W-1:0]   imm_sel;
    logic [`REG_ADDR_W-1:0]  rd, rs1, rs2;
    logic [`XLEN-1:0]        imm;
    logic                    illegal, rf_we, op_a_pc, op_b_imm;
    logic                    lsu_re, lsu_we, lsu_unsigned, is_branch, is_jump;
    logic [`WB_SEL_W-1:0]    wb_sel;
    logic [`ALU_OP_W-1:0]    alu_op;
    logic [`MEM_W_W-1:0]     lsu_width;
    logic [`BR_OP_W-1:0]     br_op;
    logic [PAYLOAD_W-1:0]    dec_payload;
    logic [PAYLOAD_W-1:0]    out_payload;

    assign instr_w.raw = instr_i;

    rv_ctrl_decoder i_ctrl_decoder (
        .instr_i        (instr_w),
        .illegal_o      (illegal),
        .rf_we_o        (rf_we),
        .op_a_pc_o      (op_a_pc),
        .op_b_imm_o     (op_b_imm),
        .lsu_re_o       (lsu_re),
        .lsu_we_o       (lsu_we),
        .lsu_unsigned_o (lsu_unsigned),
        .is_branch_o    (is_branch),
        .is_jump_o      (is_jump),
        .alu_op_o       (alu_op),
        .wb_sel_o       (wb_sel),
        .lsu_width_o    (lsu_width),
        .br_op_o        (br_op),
        .imm_sel_o      (imm_sel),
        .rd_o           (rd),
        .rs1_o          (rs1),
        .rs2_o          (rs2)
    );

    rv_imm_gen i_imm_gen (
        .instr_i   (instr_w),
        .imm_sel_i (imm_sel),
        .imm_o     (imm)
    );

    // Same field order on both sides of the buffer
    assign dec_payload = {illegal, rf_we, wb_sel, alu_op, op_a_pc, op_b_imm,
                          lsu_re, lsu_we, lsu_width, lsu_unsigned,
                          is_branch, is_jump, br_op, rd, rs1, rs2, imm};

    id_ex_skid #(
        .DATA_W (PAYLOAD_W)
    ) i_id_ex_skid (
        .clk_i       (clk_i),
        .reset_i     (reset_i),
        .in_valid_i  (instr_valid_i),
        .in_data_i   (dec_payload),
        .in_ready_o  (instr_ready_o),
        .out_valid_o (dec_valid_o),
        .out_data_o  (out_payload),
        .out_ready_i (dec_ready_i)
    );

    assign {illegal_o, rf_we_o, wb_sel_o, alu_op_o, op_a_pc_o, op_b_imm_o,
            lsu_re_o, lsu_we_o, lsu_width_o, lsu_unsigned_o,
            is_branch_o, is_jump_o, br_op_o, rd_o, rs1_o, rs2_o, imm_o} = out_payload;

endmodule

//--- logic/rv_imm_gen.sv
`timescale 1ns/1ps
`include "rv_decode_settings.svh"

module rv_imm_gen (
    input  rv_decode_pkg::instr_u   instr_i,
    input  logic [`IMM_SEL_W-1:0]   imm_sel_i,
    output logic [`XLEN-1:0]        imm_o
);

    always_comb begin
        case (imm_sel_i)
            `IMM_I: imm_o = {{(`XLEN-12){instr_i.i_type.imm[11]}}, instr_i.i_type.imm};
            `IMM_S: imm_o = {{(`XLEN-12){instr_i.s_type.imm_11_5[6]}},
                             instr_i.s_type.imm_11_5, instr_i.s_type.imm_4_0};
            // Branch and jump offsets are halfword aligned
            `IMM_B: imm_o = {{(`XLEN-12){instr_i.b_type.imm_12}},
                             instr_i.b_type.imm_11, instr_i.b_type.imm_10_5,
                             instr_i.b_type.imm_4_1, 1'b0};
            `IMM_U: imm_o = {instr_i.u_type.imm_31_12, 12'b0};
            `IMM_J: imm_o = {{(`XLEN-20){instr_i.j_type.imm_20}},
                             instr_i.j_type.imm_19_12, instr_i.j_type.imm_11,
                             instr_i.j_type.imm_10_1, 1'b0};
            default: imm_o = '0;
        endcase
    end

endmodule

//--- src.f
+incdir+logic
logic/rv_decode_pkg.sv
logic/rv_ctrl_decoder.sv
logic/rv_imm_gen.sv
logic/id_ex_skid.sv
logic/rv_decode_stage.sv
test/rv_decode_assertions.sv
test/tb_rv_decode_stage.sv

//--- test/rv_decode_assertions.sv
`timescale 1ns/1ps
`include "rv_decode_settings.svh"

module rv_decode_assertions (
    input logic                    clk_i,
    input logic                    reset_i,
    input logic [`XLEN-1:0]        instr_i,
    input logic                    instr_valid_i,
    input logic                    instr_ready_o,
    input logic                    dec_valid_o,
    input logic                    dec_ready_i,
    input logic [`REG_ADDR_W-1:0]  rd_o,
    input logic [`REG_ADDR_W-1:0]  rs1_o,
    input logic [`REG_ADDR_W-1:0]  rs2_o,
    input logic [`XLEN-1:0]        imm_o,
    input logic                    illegal_o,
    input logic                    rf_we_o,
    input logic [`WB_SEL_W-1:0]    wb_sel_o,
    input logic [`ALU_OP_W-1:0]    alu_op_o,
    input logic                    op_a_pc_o,
    input logic                    op_b_imm_o,
    input logic                    lsu_re_o,
    input logic                    lsu_we_o,
    input logic [`MEM_W_W-1:0]     lsu_width_o,
    input logic                    lsu_unsigned_o,
    input logic                    is_branch_o,
    input logic                    is_jump_o,
    input logic [`BR_OP_W-1:0]     br_op_o
);

    import rv_decode_pkg::*;

    localparam int FLAGS_W  = 6;
    localparam int FIELDS_W = `WB_SEL_W + `ALU_OP_W + 2 + `MEM_W_W + 1 + `BR_OP_W;
    localparam int REGS_W   = 3 * `REG_ADDR_W;
    localparam int EXP_W    = FLAGS_W + FIELDS_W + REGS_W + `XLEN;

    int unsigned         fail_count = 0;
    logic [EXP_W-1:0]    exp_mem [0:7];
    logic [2:0]          wr_ptr;
    logic [2:0]          rd_ptr;
    logic [2:0]          held;
    logic                seen_xfer;
    logic                in_xfer;
    logic                out_xfer;
    logic [EXP_W-1:0]    exp_head;
    logic [EXP_W-1:0]    act_all;
    logic [EXP_W-1:0]    prev_out;
    logic [FLAGS_W-1:0]  exp_flags;
    logic [FIELDS_W-1:0] exp_fields;
    logic [REGS_W-1:0]   exp_regs;
    logic [`XLEN-1:0]    exp_imm;
    logic [FLAGS_W-1:0]  act_flags;
    logic [FIELDS_W-1:0] act_fields;
    logic [REGS_W-1:0]   act_regs;

    function automatic logic [`ALU_OP_W-1:0] alu_ref(input logic [2:0] f3, input logic alt);
        case (f3)
            3'd0:    return alt ? `ALU_SUB : `ALU_ADD;
            3'd1:    return `ALU_SLL;
            3'd2:    return `ALU_SLT;
            3'd3:    return `ALU_SLTU;
            3'd4:    return `ALU_XOR;
            3'd5:    return alt ? `ALU_SRA : `ALU_SRL;
            3'd6:    return `ALU_OR;
            default: return `ALU_AND;
        endcase
    endfunction

    // Reference decode of one RV32I word, laid out as flags, fields, registers, immediate
    function automatic logic [EXP_W-1:0] decode_ref(input instr_u w);
        logic [6:0]            op;
        logic [2:0]            f3;
        logic [6:0]            f7;
        logic [31:0]           b;
        logic                  bad;
        logic                  we;
        logic                  pc;
        logic                  bimm;
        logic                  re;
        logic                  st;
        logic                  br;
        logic                  jmp;
        logic                  uns;
        logic [`WB_SEL_W-1:0]  wb;
        logic [`ALU_OP_W-1:0]  alu;
        logic [`MEM_W_W-1:0]   width;
        logic [`BR_OP_W-1:0]   cond;
        logic [`XLEN-1:0]      imm;
        op = w.r_type.opcode;
        f3 = w.r_type.funct3;
        f7 = w.r_type.funct7;
        b = w.raw;
        {bad, we, pc, bimm, re, st, br, jmp, uns} = '0;
        wb = `WB_ALU;
        alu = `ALU_ADD;
        width = '0;
        cond = '0;
        imm = '0;
        case (op)
            `OPC_LUI: begin
                {we, bimm} = 2'b11;
                alu = `ALU_B;
                imm = {b[31:12], 12'b0};
            end
            `OPC_AUIPC: begin
                {we, pc, bimm} = 3'b111;
                imm = {b[31:12], 12'b0};
            end
            `OPC_JAL: begin
                {we, jmp, pc, bimm} = 4'b1111;
                wb = `WB_PC4;
                imm = {{11{b[31]}}, b[31], b[19:12], b[20], b[30:21], 1'b0};
            end
            `OPC_JALR: begin
                {we, jmp, bimm} = 3'b111;
                wb = `WB_PC4;
                bad = (f3 != 3'd0);
                imm = {{20{b[31]}}, b[31:20]};
            end
            `OPC_BRANCH: begin
                br = 1'b1;
                cond = f3;
                bad = (f3 == 3'd2) || (f3 == 3'd3);
                alu = !f3[2] ? `ALU_SUB : (f3[1] ? `ALU_SLTU : `ALU_SLT);
                imm = {{19{b[31]}}, b[31], b[7], b[30:25], b[11:8], 1'b0};
            end
            `OPC_LOAD: begin
                {we, re, bimm} = 3'b111;
                wb = `WB_MEM;
                width = f3[1:0];
                uns = f3[2];
                bad = !(f3 inside {3'd0, 3'd1, 3'd2, 3'd4, 3'd5});
                imm = {{20{b[31]}}, b[31:20]};
            end
            `OPC_STORE: begin
                {st, bimm} = 2'b11;
                width = f3[1:0];
                bad = !(f3 inside {3'd0, 3'd1, 3'd2});
                imm = {{20{b[31]}}, b[31:25], b[11:7]};
            end
            `OPC_OP_IMM: begin
                {we, bimm} = 2'b11;
                alu = alu_ref(f3, (f3 == 3'd5) && f7[5]);
                bad = ((f3 == 3'd1) && (f7 != 7'h00)) ||
                      ((f3 == 3'd5) && (f7 != 7'h00) && (f7 != 7'h20));
                imm = {{20{b[31]}}, b[31:20]};
            end
            `OPC_OP: begin
                we = 1'b1;
                alu = alu_ref(f3, f7[5]);
                bad = !((f7 == 7'h00) || ((f7 == 7'h20) && ((f3 == 3'd0) || (f3 == 3'd5))));
            end
            default: bad = 1'b1;
        endcase
        if (bad) begin
            {we, re, st, br, jmp} = '0;
        end
        return {bad, we, re, st, br, jmp, wb, alu, pc, bimm, width, uns, cond,
                w.r_type.rd, w.r_type.rs1, w.r_type.rs2, imm};
    endfunction

    assign in_xfer  = instr_valid_i && instr_ready_o;
    assign out_xfer = dec_valid_o && dec_ready_i;
    assign held     = wr_ptr - rd_ptr;
    assign exp_head = exp_mem[rd_ptr];

    assign {exp_flags, exp_fields, exp_regs, exp_imm} = exp_head;
    assign act_flags  = {illegal_o, rf_we_o, lsu_re_o, lsu_we_o, is_branch_o, is_jump_o};
    assign act_fields = {wb_sel_o, alu_op_o, op_a_pc_o, op_b_imm_o, lsu_width_o,
                         lsu_unsigned_o, br_op_o};
    assign act_regs   = {rd_o, rs1_o, rs2_o};
    assign act_all    = {act_flags, act_fields, act_regs, imm_o};

    // Expected decodes in acceptance order
    always @(posedge clk_i) begin
        prev_out <= act_all;
        if (reset_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            seen_xfer <= 1'b0;
        end else begin
            if (in_xfer) begin
                exp_mem[wr_ptr] <= decode_ref(instr_i);
                wr_ptr <= wr_ptr + 3'd1;
                seen_xfer <= 1'b1;
            end
            if (out_xfer) begin
                rd_ptr <= rd_ptr + 3'd1;
            end
        end
    end

    a_idle_after_reset: assert property (@(posedge clk_i) disable iff (reset_i)
        !seen_xfer |-> !dec_valid_o && instr_ready_o)
        else begin
            fail_count++;
            $error("ERR %0t dec_valid_o,instr_ready_o expected 0,1 actual %b,%b",
                   $time, $sampled(dec_valid_o), $sampled(instr_ready_o));
        end

    a_regs_in_order: assert property (@(posedge clk_i) disable iff (reset_i)
        out_xfer |-> act_regs == exp_regs)
        else begin
            fail_count++;
            $error("ERR %0t rd_o,rs1_o,rs2_o expected %h actual %h",
                   $time, $sampled(exp_regs), $sampled(act_regs));
        end

    a_imm: assert property (@(posedge clk_i) disable iff (reset_i)
        out_xfer |-> imm_o == exp_imm)
        else begin
            fail_count++;
            $error("ERR %0t imm_o expected %h actual %h",
                   $time, $sampled(exp_imm), $sampled(imm_o));
        end

    a_flags: assert property (@(posedge clk_i) disable iff (reset_i)
        out_xfer |-> act_flags == exp_flags)
        else begin
            fail_count++;
            $error("ERR %0t %s expected %b actual %b", $time,
                   "illegal_o,rf_we_o,lsu_re_o,lsu_we_o,is_branch_o,is_jump_o",
                   $sampled(exp_flags), $sampled(act_flags));
        end

    a_fields: assert property (@(posedge clk_i) disable iff (reset_i)
        out_xfer |-> act_fields == exp_fields)
        else begin
            fail_count++;
            $error("ERR %0t %s expected %h actual %h", $time,
                   "wb_sel_o,alu_op_o,op_a_pc_o,op_b_imm_o,lsu_width_o,lsu_unsigned_o,br_op_o",
                   $sampled(exp_fields), $sampled(act_fields));
        end

    a_illegal_quiet: assert property (@(posedge clk_i) disable iff (reset_i)
        out_xfer && illegal_o |-> act_flags[FLAGS_W-2:0] == '0)
        else begin
            fail_count++;
            $error("ERR %0t %s expected 00000 actual %b", $time,
                   "rf_we_o,lsu_re_o,lsu_we_o,is_branch_o,is_jump_o",
                   $sampled(act_flags[FLAGS_W-2:0]));
        end

    a_hold: assert property (@(posedge clk_i) disable iff (reset_i)
        dec_valid_o && !dec_ready_i |=> dec_valid_o && (act_all == prev_out))
        else begin
            fail_count++;
            $error("ERR %0t decoded outputs under back-pressure expected %h actual %h",
                   $time, $sampled(prev_out), $sampled(act_all));
        end

    a_ready_level: assert property (@(posedge clk_i) disable iff (reset_i)
        instr_ready_o == (held < 3'd2))
        else begin
            fail_count++;
            $error("ERR %0t instr_ready_o expected %b actual %b",
                   $time, $sampled(held < 3'd2), $sampled(instr_ready_o));
        end

    a_valid_level: assert property (@(posedge clk_i) disable iff (reset_i)
        dec_valid_o == (held != 3'd0))
        else begin
            fail_count++;
            $error("ERR %0t dec_valid_o expected %b actual %b",
                   $time, $sampled(held != 3'd0), $sampled(dec_valid_o));
        end

endmodule

//--- test/tb_rv_decode_stage.sv
`timescale 1ns/1ps
`include "rv_decode_settings.svh"

module tb_rv_decode_stage;

    localparam int WAIT_LIMIT = 200;

    logic                   clk_i;
    logic                   reset_i;
    logic [`XLEN-1:0]       instr_i;
    logic                   instr_valid_i;
    logic                   instr_ready_o;
    logic                   dec_valid_o;
    logic                   dec_ready_i;
    logic [`REG_ADDR_W-1:0] rd_o;
    logic [`REG_ADDR_W-1:0] rs1_o;
    logic [`REG_ADDR_W-1:0] rs2_o;
    logic [`XLEN-1:0]       imm_o;
    logic                   illegal_o;
    logic                   rf_we_o;
    logic [`WB_SEL_W-1:0]   wb_sel_o;
    logic [`ALU_OP_W-1:0]   alu_op_o;
    logic                   op_a_pc_o;
    logic                   op_b_imm_o;
    logic                   lsu_re_o;
    logic                   lsu_we_o;
    logic [`MEM_W_W-1:0]    lsu_width_o;
    logic                   lsu_unsigned_o;
    logic                   is_branch_o;
    logic                   is_jump_o;
    logic [`BR_OP_W-1:0]    br_op_o;

    int unsigned timeouts;
    int unsigned low_left;

    rv_decode_stage i_dut (.*);

    bind rv_decode_stage rv_decode_assertions i_checks (.*);

    always #4 clk_i = ~clk_i;

    function automatic logic [31:0] pack_word(input logic [6:0] f7, input logic [4:0] rs2,
                                              input logic [4:0] rs1, input logic [2:0] f3,
                                              input logic [4:0] rd, input logic [6:0] op);
        return {f7, rs2, rs1, f3, rd, op};
    endfunction

    // Random legal RV32I word with random register fields
    function automatic logic [31:0] legal_word();
        logic [31:0] w;
        w = $urandom();
        case ($urandom_range(0, 8))
            0: w[6:0] = `OPC_LUI;
            1: w[6:0] = `OPC_AUIPC;
            2: w[6:0] = `OPC_JAL;
            3: begin
                w[6:0] = `OPC_JALR;
                w[14:12] = 3'd0;
            end
            4: begin
                w[6:0] = `OPC_BRANCH;
                if (w[14:13] == 2'b01) begin
                    w[13] = 1'b0;
                end
            end
            5: begin
                w[6:0] = `OPC_LOAD;
                if (w[14]) begin
                    w[13] = 1'b0;
                end else if (w[13:12] == 2'b11) begin
                    w[12] = 1'b0;
                end
            end
            6: begin
                w[6:0] = `OPC_STORE;
                w[14] = 1'b0;
                if (w[13:12] == 2'b11) begin
                    w[12] = 1'b0;
                end
            end
            7: begin
                w[6:0] = `OPC_OP_IMM;
                // Only right shifts may set funct7 bit 5
                if (w[14:12] == 3'd1) begin
                    w[31:25] = 7'h00;
                end else if (w[14:12] == 3'd5) begin
                    w[31:25] = {1'b0, w[30], 5'b0};
                end
            end
            default: begin
                w[6:0] = `OPC_OP;
                w[31:25] = {1'b0, ((w[14:12] == 3'd0) || (w[14:12] == 3'd5)) && w[30], 5'b0};
            end
        endcase
        return w;
    endfunction

    // Called on a falling edge, returns on the falling edge after the transfer
    task automatic send_instr(input logic [31:0] word);
        int unsigned waited;
        waited = 0;
        instr_i = word;
        instr_valid_i = 1'b1;
        while (!instr_ready_o && (waited < WAIT_LIMIT)) begin
            @(negedge clk_i);
            waited++;
        end
        if (!instr_ready_o) begin
            timeouts++;
            $display("Timeout: instruction %h was not accepted within %0d cycles",
                     word, WAIT_LIMIT);
        end
        @(negedge clk_i);
    endtask

    // Execute side, low one cycle in three with occasional long stalls
    always @(negedge clk_i) begin
        if (low_left > 0) begin
            dec_ready_i = 1'b0;
            low_left--;
        end else if ($urandom_range(0, 19) == 0) begin
            dec_ready_i = 1'b0;
            low_left = 5;
        end else begin
            dec_ready_i = ($urandom_range(0, 2) != 0);
        end
    end

    initial begin
        logic [6:0]  f7_set [0:3];
        int unsigned fails;
        int unsigned waited;
        void'($urandom(32'hd7e9_262b));
        f7_set = '{7'h00, 7'h20, 7'h01, 7'h7f};
        clk_i = 1'b0;
        reset_i = 1'b1;
        instr_i = '0;
        instr_valid_i = 1'b0;
        dec_ready_i = 1'b0;
        timeouts = 0;
        low_left = 0;
        repeat (8) @(negedge clk_i);
        reset_i = 1'b0;
        repeat (3) @(negedge clk_i);

        send_instr(pack_word(7'h5a, 5'd3, 5'd4, 3'd6, 5'd5, `OPC_LUI));
        send_instr(pack_word(7'h12, 5'd7, 5'd8, 3'd1, 5'd9, `OPC_AUIPC));
        send_instr(pack_word(7'h66, 5'd11, 5'd12, 3'd5, 5'd1, `OPC_JAL));
        send_instr(pack_word(7'h41, 5'd13, 5'd2, 3'd0, 5'd1, `OPC_JALR));
        send_instr(pack_word(7'h41, 5'd13, 5'd2, 3'd4, 5'd1, `OPC_JALR));
        for (int f3 = 0; f3 < 8; f3++) begin
            send_instr(pack_word(7'h73, 5'd6, 5'd7, f3[2:0], 5'd21, `OPC_BRANCH));
            send_instr(pack_word(7'h2c, 5'd16, 5'd17, f3[2:0], 5'd18, `OPC_LOAD));
            send_instr(pack_word(7'h6e, 5'd19, 5'd20, f3[2:0], 5'd22, `OPC_STORE));
        end
        // OP and OP-IMM with base, alternate, M extension and all-ones funct7
        for (int k = 0; k < 4; k++) begin
            for (int f3 = 0; f3 < 8; f3++) begin
                send_instr(pack_word(f7_set[k], 5'd23, 5'd24, f3[2:0], 5'd25, `OPC_OP_IMM));
                send_instr(pack_word(f7_set[k], 5'd26, 5'd27, f3[2:0], 5'd28, `OPC_OP));
            end
        end
        send_instr(32'h0ff0_000f);
        send_instr(32'h0000_0073);
        send_instr(32'h0000_0000);
        send_instr(32'hffff_ffff);

        for (int n = 0; n < 300; n++) begin
            if ($urandom_range(0, 15) == 0) begin
                send_instr($urandom());
            end else begin
                send_instr(legal_word());
            end
        end
        instr_valid_i = 1'b0;

        waited = 0;
        while (dec_valid_o && (waited < WAIT_LIMIT)) begin
            @(negedge clk_i);
            waited++;
        end
        if (dec_valid_o) begin
            timeouts++;
            $display("Timeout: decoded instructions were not drained within %0d cycles",
                     WAIT_LIMIT);
        end
        repeat (2) @(negedge clk_i);

        fails = i_dut.i_checks.fail_count;
        $display("Assertion failures: %0d, timeouts: %0d", fails, timeouts);
        if ((fails == 0) && (timeouts == 0)) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule
